//--- fetch_ctl_pkg.sv
// Covers only the opcodes fetch control cares about; exception codes follow the RISC-V mcause encoding
package fetch_ctl_pkg;

	// Instruction word and field widths
	localparam int unsigned ILEN       = 32;
	localparam int unsigned OPCODE_LEN = 7;
	localparam int unsigned FUNCT3_LEN = 3;
	localparam int unsigned FUNCT7_LEN = 7;

	// Major opcodes seen by the classifier
	typedef enum logic [OPCODE_LEN-1:0] {
		OPC_LOAD     = 7'b0000011,
		OPC_MISC_MEM = 7'b0001111,
		OPC_BRANCH   = 7'b1100011,
		OPC_SYSTEM   = 7'b1110011
	} opcode_t;

	// Minor opcode fields
	localparam logic [FUNCT3_LEN-1:0] FUNCT3_FENCE      = 3'b000;
	localparam logic [FUNCT3_LEN-1:0] FUNCT3_FENCE_I    = 3'b001;
	localparam logic [FUNCT3_LEN-1:0] FUNCT3_PRIV       = 3'b000;
	localparam logic [FUNCT7_LEN-1:0] FUNCT7_SFENCE_VMA = 7'b0001001;

	// Classes the control FSM reacts to
	typedef enum logic [2:0] {
		CLS_OTHER      = 3'd0,
		CLS_BRANCH     = 3'd1,
		CLS_LOAD       = 3'd2,
		CLS_FENCE      = 3'd3,
		CLS_FENCE_I    = 3'd4,
		CLS_SFENCE_VMA = 3'd5
	} instr_class_t;

	// Exception cause, zero value is the reset cause
	typedef enum logic [3:0] {
		EXC_INSTR_MISALIGNED = 4'd0,
		EXC_INSTR_FAULT      = 4'd1,
		EXC_ILLEGAL_INSTR    = 4'd2,
		EXC_BREAKPOINT       = 4'd3,
		EXC_LOAD_MISALIGNED  = 4'd4,
		EXC_LOAD_FAULT       = 4'd5,
		EXC_STORE_MISALIGNED = 4'd6,
		EXC_STORE_FAULT      = 4'd7,
		EXC_ECALL            = 4'd8
	} except_code_t;

	// Control FSM states
	typedef enum logic [1:0] {
		ST_RESET  = 2'd0,
		ST_RUN    = 2'd1,
		ST_DRAIN  = 2'd2,
		ST_EXCEPT = 2'd3
	} ctl_state_t;

	// Fetch control bundle, 6 bits
	typedef struct packed {
		logic         stall;
		logic         flush;
		except_code_t cause;
	} ctl_out_t;

endpackage

//--- instr_classifier.sv
// One cycle latency from instr_valid_i; class_o is only meaningful while class_valid_o is high
`timescale 1ns/1ps

module instr_classifier
	import fetch_ctl_pkg::*;
(
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            instr_valid_i,
	input  logic [ILEN-1:0] instr_i,
	output logic            class_valid_o,
	output instr_class_t    class_o
);

	// Instruction fields
	opcode_t               opcode;
	logic [FUNCT3_LEN-1:0] funct3;
	logic [FUNCT7_LEN-1:0] funct7;
	instr_class_t          class_d;
	logic                  valid_q;
	instr_class_t          class_q;

	assign opcode = opcode_t'(instr_i[OPCODE_LEN-1:0]);
	assign funct3 = instr_i[14 -: FUNCT3_LEN];
	assign funct7 = instr_i[ILEN-1 -: FUNCT7_LEN];

	// Decode into a class
	always_comb begin
		class_d = CLS_OTHER;
		case (opcode)
			OPC_BRANCH: class_d = CLS_BRANCH;
			OPC_LOAD:   class_d = CLS_LOAD;
			OPC_MISC_MEM: begin
				// Unlisted funct3 stays CLS_OTHER
				if (funct3 == FUNCT3_FENCE) begin
					class_d = CLS_FENCE;
				end else if (funct3 == FUNCT3_FENCE_I) begin
					class_d = CLS_FENCE_I;
				end
			end
			OPC_SYSTEM: begin
				// Only sfence.vma matters, ecall and CSR ops fall through
				if (funct3 == FUNCT3_PRIV && funct7 == FUNCT7_SFENCE_VMA) begin
					class_d = CLS_SFENCE_VMA;
				end
			end
			default: class_d = CLS_OTHER;
		endcase
	end

	// Valid strobe
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= instr_valid_i;
		end
	end

	// Class payload, loaded only on a valid word
	always_ff @(posedge clk_i) begin
		if (instr_valid_i) begin
			class_q <= class_d;
		end
	end

	assign class_valid_o = valid_q;
	assign class_o       = class_q;

endmodule

//--- except_tracker.sv
// Keeps only the first raise until acknowledged; a raise in the ack cycle becomes the new pending one
`timescale 1ns/1ps

module except_tracker
	import fetch_ctl_pkg::*;
(
	input  logic         clk_i,
	input  logic         rst_n_i,
	input  logic         except_raised_i,
	input  except_code_t except_code_i,
	input  logic         exc_ack_i,
	output logic         exc_pending_o,
	output except_code_t exc_code_o
);

	logic         pending_q;
	except_code_t code_q;
	logic         capture;

	// Free slot when idle or being acked this cycle
	assign capture = except_raised_i && (!pending_q || exc_ack_i);

	// Pending flag
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pending_q <= 1'b0;
		end else if (capture) begin
			pending_q <= 1'b1;
		end else if (exc_ack_i) begin
			pending_q <= 1'b0;
		end
	end

	// Cause of the first raise
	// Later raises in a burst leave this alone
	always_ff @(posedge clk_i) begin
		if (capture) begin
			code_q <= except_code_i;
		end
	end

	assign exc_pending_o = pending_q;
	assign exc_code_o    = code_q;

endmodule

//--- cu_fsm.sv
// DRAIN_CYCLES must be at least 1; main stall freezes RUN and DRAIN, never the one-cycle ST_EXCEPT
`timescale 1ns/1ps

module cu_fsm
	import fetch_ctl_pkg::*;
#(
	parameter int unsigned DRAIN_CYCLES = 4
) (
	input  logic         clk_i,
	input  logic         rst_n_i,
	input  logic         main_cu_stall_i,
	input  logic         class_valid_i,
	input  instr_class_t class_i,
	input  logic         exc_pending_i,
	input  except_code_t exc_code_i,
	output logic         exc_ack_o,
	output ctl_out_t     ctl_o
);

	// Counter width of at least one bit
	localparam int unsigned CNT_W = (DRAIN_CYCLES > 1) ? $clog2(DRAIN_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(DRAIN_CYCLES - 1);

	ctl_state_t       state_q;
	ctl_state_t       state_d;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] cnt_d;
	logic             is_drain_cls;
	ctl_out_t         ctl_q;
	ctl_out_t         ctl_d;
	logic             ack_q;

	// Fences that need the pipe drained
	assign is_drain_cls = class_valid_i &&
		(class_i == CLS_FENCE_I || class_i == CLS_SFENCE_VMA);

	// Next state and drain counter
	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q;
		case (state_q)
			ST_RESET: begin
				state_d = ST_RUN;
			end
			ST_RUN: begin
				// Exceptions win over fences
				if (!main_cu_stall_i) begin
					if (exc_pending_i) begin
						state_d = ST_EXCEPT;
					end else if (is_drain_cls) begin
						state_d = ST_DRAIN;
						cnt_d   = CNT_LOAD;
					end
				end
			end
			ST_DRAIN: begin
				// Only cycles with main stall low count
				// Incoming classes are dropped here
				if (!main_cu_stall_i) begin
					if (exc_pending_i) begin
						state_d = ST_EXCEPT;
					end else if (cnt_q == '0) begin
						state_d = ST_RUN;
					end else begin
						cnt_d = cnt_q - 1'b1;
					end
				end
			end
			ST_EXCEPT: begin
				// Single flush cycle
				state_d = ST_RUN;
			end
			default: state_d = ST_RESET;
		endcase
	end

	// Outputs follow the next state, so they appear with it
	always_comb begin
		ctl_d       = ctl_q;
		ctl_d.stall = (state_d == ST_DRAIN);
		ctl_d.flush = (state_d == ST_EXCEPT);
		// Cause sampled on the way into ST_EXCEPT
		if (state_d == ST_EXCEPT) begin
			ctl_d.cause = exc_code_i;
		end
	end

	// State, counter and outputs
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_RESET;
			cnt_q   <= '0;
			ctl_q   <= '{stall: 1'b0, flush: 1'b0, cause: EXC_INSTR_MISALIGNED};
			ack_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			ctl_q   <= ctl_d;
			// Ack pulses with flush and clears the tracker at the next edge
			ack_q   <= (state_d == ST_EXCEPT);
		end
	end

	assign ctl_o     = ctl_q;
	assign exc_ack_o = ack_q;

endmodule

//--- fetch_ctl_top.sv
// Fetch must not present instructions while ctl_o.stall is high; DRAIN_CYCLES must be at least 1
`timescale 1ns/1ps

module fetch_ctl_top
	import fetch_ctl_pkg::*;
#(
	parameter int unsigned DRAIN_CYCLES = 4
) (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            instr_valid_i,
	input  logic [ILEN-1:0] instr_i,
	input  logic            main_cu_stall_i,
	input  logic            except_raised_i,
	input  except_code_t    except_code_i,
	output ctl_out_t        ctl_o
);

	// Classifier to FSM
	logic         class_valid;
	instr_class_t class_q;
	// Tracker and FSM handshake
	logic         exc_pending;
	except_code_t exc_code;
	logic         exc_ack;

	instr_classifier u_classifier (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.class_valid_o (class_valid),
		.class_o       (class_q)
	);

	except_tracker u_tracker (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.except_raised_i (except_raised_i),
		.except_code_i   (except_code_i),
		.exc_ack_i       (exc_ack),
		.exc_pending_o   (exc_pending),
		.exc_code_o      (exc_code)
	);

	cu_fsm #(
		.DRAIN_CYCLES (DRAIN_CYCLES)
	) u_fsm (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.main_cu_stall_i (main_cu_stall_i),
		.class_valid_i   (class_valid),
		.class_i         (class_q),
		.exc_pending_i   (exc_pending),
		.exc_code_i      (exc_code),
		.exc_ack_o       (exc_ack),
		.ctl_o           (ctl_o)
	);

endmodule

//--- tb_fetch_ctl.sv
// Compares ctl_o each cycle with a rule-based model; no instruction is issued while stalled
`timescale 1ns/1ps

module tb_fetch_ctl
	import fetch_ctl_pkg::*;
();

	localparam int unsigned CLK_PERIOD   = 10;
	localparam int unsigned DRAIN_CYCLES = 4;
	// Cycle budget of reset, plain, drain, flush, abort and back-pressure tests
	localparam int unsigned TEST_CYCLES  = 10 + 40 + 50 + 30 + 20 + 120;
	localparam int unsigned WATCHDOG_NS  = (TEST_CYCLES * 2 + 50) * CLK_PERIOD;

	logic            clk_i;
	logic            rst_n_i;
	logic            instr_valid_i;
	logic [ILEN-1:0] instr_i;
	logic            main_cu_stall_i;
	logic            except_raised_i;
	except_code_t    except_code_i;
	ctl_out_t        ctl_o;

	// Reference model
	logic         m_cls_valid;
	instr_class_t m_cls;
	logic         m_pend;
	except_code_t m_code;
	ctl_state_t   m_state;
	int unsigned  m_left;
	except_code_t m_cause;
	ctl_out_t     exp_ctl;

	// Per-test counters
	string        test_name;
	int unsigned  stall_cycles;
	int unsigned  drain_run;
	int unsigned  flush_count;
	except_code_t last_cause;
	logic [15:0]  lfsr_q;
	logic         bp_en;
	int unsigned  pick;

	fetch_ctl_top #(
		.DRAIN_CYCLES (DRAIN_CYCLES)
	) u_dut (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.instr_valid_i   (instr_valid_i),
		.instr_i         (instr_i),
		.main_cu_stall_i (main_cu_stall_i),
		.except_raised_i (except_raised_i),
		.except_code_i   (except_code_i),
		.ctl_o           (ctl_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [ILEN-1:0] encode_instr(input logic [6:0] opc, input logic [2:0] f3,
		input logic [6:0] f7);
		return {f7, 10'd0, f3, 5'd0, opc};
	endfunction

	// Expected class straight from the decode rules
	function automatic instr_class_t expect_class(input logic [ILEN-1:0] w);
		if (w[6:0] == OPC_BRANCH) return CLS_BRANCH;
		if (w[6:0] == OPC_LOAD) return CLS_LOAD;
		if (w[6:0] == OPC_MISC_MEM && w[14:12] == 3'b000) return CLS_FENCE;
		if (w[6:0] == OPC_MISC_MEM && w[14:12] == 3'b001) return CLS_FENCE_I;
		if (w[6:0] == OPC_SYSTEM && w[14:12] == 3'b000 && w[31:25] == 7'b0001001) begin
			return CLS_SFENCE_VMA;
		end
		return CLS_OTHER;
	endfunction

	function automatic string format_ctl(input ctl_out_t c);
		return $sformatf("stall=%0b flush=%0b cause=%0d", c.stall, c.flush, c.cause);
	endfunction

	task automatic take_bits(input int unsigned n, output int unsigned v);
		v = 0;
		for (int unsigned i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = (v << 1) | lfsr_q[0];
		end
	endtask

	task automatic stop_on_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic report_mismatch(input string name, input ctl_out_t exp, input ctl_out_t act);
		$display("MISMATCH test=%s expected %s actual %s", name, format_ctl(exp),
			format_ctl(act));
		stop_on_failure();
	endtask

	task automatic check_value(input string name, input int unsigned exp, input int unsigned act);
		assert (exp == act) else begin
			$display("MISMATCH test=%s expected=%0d actual=%0d", name, exp, act);
			stop_on_failure();
		end
	endtask

	// Model updates on the same edges as the DUT
	always @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			m_cls_valid <= 1'b0;
			m_cls       <= CLS_OTHER;
			m_pend      <= 1'b0;
			m_code      <= EXC_INSTR_MISALIGNED;
			m_state     <= ST_RESET;
			m_left      <= 0;
			m_cause     <= EXC_INSTR_MISALIGNED;
		end else begin
			m_cls_valid <= instr_valid_i;
			if (instr_valid_i) begin
				m_cls <= expect_class(instr_i);
			end
			// First raise wins; the ack cycle frees the slot
			if (except_raised_i && (!m_pend || m_state == ST_EXCEPT)) begin
				m_pend <= 1'b1;
				m_code <= except_code_i;
			end else if (m_state == ST_EXCEPT) begin
				m_pend <= 1'b0;
			end
			if (m_state == ST_RESET || m_state == ST_EXCEPT) begin
				m_state <= ST_RUN;
			end else if (!main_cu_stall_i) begin
				if (m_pend) begin
					m_state <= ST_EXCEPT;
					m_cause <= m_code;
				end else if (m_state == ST_RUN) begin
					if (m_cls_valid && (m_cls == CLS_FENCE_I || m_cls == CLS_SFENCE_VMA)) begin
						m_state <= ST_DRAIN;
						m_left  <= DRAIN_CYCLES;
					end
				end else begin
					// Drain counts only unstalled cycles
					m_left <= m_left - 1;
					if (m_left == 1) begin
						m_state <= ST_RUN;
					end
				end
			end
		end
	end

	always_comb begin
		exp_ctl.stall = (m_state == ST_DRAIN);
		exp_ctl.flush = (m_state == ST_EXCEPT);
		exp_ctl.cause = m_cause;
	end

	// Compare mid-cycle where outputs are settled
	always @(negedge clk_i) begin
		assert (ctl_o === exp_ctl) else report_mismatch(test_name, exp_ctl, ctl_o);
		if (ctl_o.stall) stall_cycles++;
		if (ctl_o.stall && !main_cu_stall_i) drain_run++;
		if (ctl_o.flush) begin
			flush_count++;
			last_cause = ctl_o.cause;
		end
	end

	// Strobes last one cycle; main stall is random only in back-pressure tests
	task automatic next_cycle();
		@(posedge clk_i);
		#1;
		instr_valid_i   = 1'b0;
		except_raised_i = 1'b0;
		main_cu_stall_i = 1'b0;
		if (bp_en) begin
			take_bits(1, pick);
			main_cu_stall_i = pick[0];
		end
	endtask

	task automatic begin_test(input string name);
		test_name    = name;
		stall_cycles = 0;
		drain_run    = 0;
		flush_count  = 0;
	endtask

	// Main stall forced low while the class reaches the FSM
	task automatic issue_instr(input logic [ILEN-1:0] w);
		next_cycle();
		instr_valid_i = 1'b1;
		instr_i       = w;
		next_cycle();
		main_cu_stall_i = 1'b0;
	endtask

	task automatic raise_exception(input except_code_t code);
		next_cycle();
		except_raised_i = 1'b1;
		except_code_i   = code;
	endtask

	task automatic wait_idle();
		next_cycle();
		while (!(m_state == ST_RUN && !m_pend && !m_cls_valid)) begin
			next_cycle();
		end
	endtask

	task automatic run_drain(input string name, input logic [ILEN-1:0] w, input int unsigned exp);
		begin_test(name);
		issue_instr(w);
		wait_idle();
		check_value(name, exp, stall_cycles);
		check_value(name, 0, flush_count);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the tests did not finish in time");
		stop_on_failure();
	end

	initial begin
		clk_i           = 1'b0;
		rst_n_i         = 1'b0;
		instr_valid_i   = 1'b0;
		instr_i         = '0;
		main_cu_stall_i = 1'b0;
		except_raised_i = 1'b0;
		except_code_i   = EXC_INSTR_MISALIGNED;
		bp_en           = 1'b0;
		lfsr_q          = 16'd26;
		begin_test("reset");
		repeat (5) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		wait_idle();

		// Branch, load and fence pass through
		begin_test("plain");
		for (int unsigned i = 0; i < 12; i++) begin
			take_bits(2, pick);
			if (pick == 1) issue_instr(encode_instr(OPC_LOAD, 3'b010, 7'd0));
			else if (pick == 2) issue_instr(encode_instr(OPC_MISC_MEM, FUNCT3_FENCE, 7'd0));
			else issue_instr(encode_instr(OPC_BRANCH, 3'b001, 7'd0));
			wait_idle();
		end
		check_value("plain", 0, stall_cycles + flush_count);

		run_drain("fence_i", encode_instr(OPC_MISC_MEM, FUNCT3_FENCE_I, 7'd0), DRAIN_CYCLES);
		run_drain("sfence_vma", encode_instr(OPC_SYSTEM, FUNCT3_PRIV, FUNCT7_SFENCE_VMA),
			DRAIN_CYCLES);
		run_drain("system_other", encode_instr(OPC_SYSTEM, FUNCT3_PRIV, 7'd0), 0);
		run_drain("misc_mem_other", encode_instr(OPC_MISC_MEM, 3'b010, 7'd0), 0);

		// Second raise lands while the first is pending
		begin_test("flush");
		raise_exception(EXC_ILLEGAL_INSTR);
		raise_exception(EXC_LOAD_FAULT);
		wait_idle();
		check_value("flush", 1, flush_count);
		check_value("flush", EXC_ILLEGAL_INSTR, last_cause);

		// Raise two cycles into the drain so three stall cycles remain visible
		begin_test("drain_abort");
		issue_instr(encode_instr(OPC_MISC_MEM, FUNCT3_FENCE_I, 7'd0));
		next_cycle();
		raise_exception(EXC_INSTR_FAULT);
		wait_idle();
		check_value("drain_abort", 3, stall_cycles);
		check_value("drain_abort", 1, flush_count);
		check_value("drain_abort", EXC_INSTR_FAULT, last_cause);

		bp_en = 1'b1;
		for (int unsigned i = 0; i < 3; i++) begin
			begin_test("bp_drain");
			issue_instr(encode_instr(OPC_MISC_MEM, FUNCT3_FENCE_I, 7'd0));
			wait_idle();
			check_value("bp_drain", DRAIN_CYCLES, drain_run);
			begin_test("bp_flush");
			raise_exception(i[0] ? EXC_ECALL : EXC_STORE_FAULT);
			raise_exception(EXC_BREAKPOINT);
			wait_idle();
			check_value("bp_flush", 1, flush_count);
			check_value("bp_flush", i[0] ? EXC_ECALL : EXC_STORE_FAULT, last_cause);
		end
		bp_en = 1'b0;
		next_cycle();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- list.f
fetch_ctl_pkg.sv
instr_classifier.sv
except_tracker.sv
cu_fsm.sv
fetch_ctl_top.sv
tb_fetch_ctl.sv

//--- Bender.yml
package:
  name: fetch_ctl

sources:
  - fetch_ctl_pkg.sv
  - instr_classifier.sv
  - except_tracker.sv
  - cu_fsm.sv
  - fetch_ctl_top.sv
  - target: test
    files:
      - tb_fetch_ctl.sv
